// File: bp_pkg.sv
package bp_pkg;

    // --------------------
    // angles
    // --------------------

    // whole degrees, 0 to 179
    localparam int k_angle_length = 8;
    // scan boundaries
    localparam logic [k_angle_length-1:0] k_angle_45 = 8'd45;
    localparam logic [k_angle_length-1:0] k_angle_90 = 8'd90;
    localparam logic [k_angle_length-1:0] k_angle_135 = 8'd135;
    // mirror point of the folded angle
    localparam logic [k_angle_length-1:0] k_angle_mirror = 8'd89;

    // --------------------
    // sizes
    // --------------------

    localparam int k_filtered_data_length = 12;
    // taps per line, one per pe
    localparam int k_no_of_partitions = 4;
    localparam int k_part_idx_length = $clog2(k_no_of_partitions);
    localparam logic [k_part_idx_length-1:0] k_last_part =
        k_part_idx_length'(k_no_of_partitions - 1);
    // lines per angle
    localparam int k_partition_size = 4;
    localparam int k_line_itr_length = $clog2(k_partition_size);
    localparam logic [k_line_itr_length-1:0] k_last_line =
        k_line_itr_length'(k_partition_size - 1);
    // bank address and depth
    localparam int k_s_length = 8;
    localparam int k_bank_words = 2 ** k_s_length;
    localparam int k_no_of_banks = 2;
    // pe_en cycles per line
    localparam int k_shift_cycles = 6;
    localparam int k_shift_cnt_length = $clog2(k_shift_cycles);
    localparam logic [k_shift_cnt_length-1:0] k_last_shift =
        k_shift_cnt_length'(k_shift_cycles - 1);

    // --------------------
    // lut constants
    // --------------------

    localparam int k_accu_length = 8;
    localparam int k_slope_entries = 12;
    localparam int k_slope_idx_length = $clog2(k_slope_entries);
    localparam logic [k_accu_length-1:0] k_sh_base_offset = 8'd16;
    localparam logic [k_accu_length-1:0] k_mp_part_offset = 8'd64;
    // round(16 * tan(4i deg))
    localparam logic [k_accu_length-1:0] k_slope_table [k_slope_entries] = '{
        8'd0, 8'd1, 8'd2, 8'd3, 8'd5, 8'd6, 8'd7, 8'd9, 8'd10, 8'd12, 8'd13, 8'd15
    };

    // --------------------
    // types
    // --------------------

    typedef enum logic {scan_x, scan_y} scan_mode_t;
    typedef enum logic {scan_forward, scan_reverse} scan_dir_t;

    typedef logic signed [k_filtered_data_length-1:0] tap_t;
    typedef tap_t [k_no_of_partitions-1:0] taps_t;

    // per-angle accumulator values
    typedef struct packed {
        logic [k_accu_length-1:0] sh_accu_base;
        logic [k_accu_length-1:0] mp_accu_base;
        logic [k_accu_length-1:0] mp_accu_part;
    } lut_val_t;

    // swappable to control
    typedef struct packed {
        logic swap;
        logic next_itr;
        logic pe_en;
    } sw_status_t;

    typedef struct packed {
        logic reset;
        logic kick;
        logic en;
        scan_mode_t scan_mode;
        scan_dir_t scan_direction;
    } pe_ctrl_t;

endpackage

// File: bp_filtered_ram.sv
`timescale 1ns/1ps

module bp_filtered_ram
(
    input  logic clk,
    // write port, loaded from outside
    input  logic wr_en,
    input  logic wr_bank,
    input  logic [bp_pkg::k_s_length-1:0] wr_addr,
    input  bp_pkg::tap_t wr_data,
    // read port of bank 0
    input  logic [bp_pkg::k_s_length-1:0] rd0_addr,
    output bp_pkg::tap_t rd0_data,
    // read port of bank 1
    input  logic [bp_pkg::k_s_length-1:0] rd1_addr,
    output bp_pkg::tap_t rd1_data
);

    // both filtered-projection banks
    bp_pkg::tap_t mem [bp_pkg::k_no_of_banks][bp_pkg::k_bank_words];

    // --------------------
    // write side
    // --------------------
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // --------------------
    // read side
    // --------------------
    // data one cycle after the address
    always_ff @(posedge clk)
    begin
        rd0_data <= mem[0][rd0_addr];
        rd1_data <= mem[1][rd1_addr];
    end

endmodule

// File: bp_angle_lut.sv
`timescale 1ns/1ps

module bp_angle_lut
(
    input  logic clk,
    input  logic [bp_pkg::k_angle_length-1:0] angle,
    output bp_pkg::lut_val_t lut_val
);

    // stage 1 signals
    logic [bp_pkg::k_angle_length-1:0] folded;
    logic [bp_pkg::k_angle_length-1:0] mirrored;
    logic [bp_pkg::k_slope_idx_length-1:0] slope_idx;
    logic [bp_pkg::k_accu_length-1:0] part_q;
    // stage 2 signals
    logic [bp_pkg::k_accu_length-1:0] slope;

    // --------------------
    // stage 1: fold
    // --------------------
    always_comb
    begin
        // second quadrant looks like the first
        if (angle < bp_pkg::k_angle_90)
            folded = angle;
        else
            folded = angle - bp_pkg::k_angle_90;
        // mirror about 45 so the slope stays below one
        if (folded < bp_pkg::k_angle_45)
            mirrored = folded;
        else
            mirrored = bp_pkg::k_angle_mirror - folded;
    end

    // table steps every 4 degrees
    always_ff @(posedge clk)
    begin
        slope_idx <= mirrored[2 +: bp_pkg::k_slope_idx_length];
        part_q <= angle + bp_pkg::k_mp_part_offset;
    end

    // --------------------
    // stage 2: table
    // --------------------
    assign slope = bp_pkg::k_slope_table[slope_idx];

    always_ff @(posedge clk)
    begin
        // shift step in 1/16 units
        lut_val.sh_accu_base <= slope + bp_pkg::k_sh_base_offset;
        // map step per line, coarse
        lut_val.mp_accu_base <= (slope >> 2) + 1'b1;
        lut_val.mp_accu_part <= part_q;
    end

endmodule

// File: bp_swappable.sv
`timescale 1ns/1ps

module bp_swappable
(
    input  logic clk,
    input  logic reset_n,
    // from swap control
    input  bp_pkg::lut_val_t lut_val,
    input  logic [bp_pkg::k_accu_length-1:0] mp_accu_init,
    input  logic swap_ack,
    input  logic next_itr_ack,
    // from bank
    input  bp_pkg::tap_t fr_val,
    // to swap control
    output bp_pkg::sw_status_t status,
    // to bank
    output logic [bp_pkg::k_s_length-1:0] fr_s_val,
    // to pes
    output bp_pkg::taps_t taps
);

    typedef enum logic [2:0] {
        idle_s,
        fill_s,
        wait_swap_s,
        shift_s,
        wait_itr_s
    } state_t;

    state_t state;
    // partition walked in fill
    logic [bp_pkg::k_part_idx_length-1:0] part_idx;
    // p times sh_accu_base, built up one step per cycle
    logic [bp_pkg::k_s_length-1:0] sh_offset;
    logic [bp_pkg::k_shift_cnt_length-1:0] shift_cnt;
    // capture pipe, one cycle behind the address
    logic cap_en;
    logic [bp_pkg::k_part_idx_length-1:0] cap_idx;
    bp_pkg::taps_t taps_q;

    // --------------------
    // fsm
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= idle_s;
            part_idx <= '0;
            shift_cnt <= '0;
        end
        else
        begin
            case (state)
                idle_s, wait_itr_s:
                    if (next_itr_ack)
                    begin
                        state <= fill_s;
                        part_idx <= '0;
                    end
                fill_s:
                begin
                    // one address per cycle
                    part_idx <= part_idx + 1'b1;
                    if (part_idx == bp_pkg::k_last_part)
                        state <= wait_swap_s;
                end
                wait_swap_s:
                    if (swap_ack)
                    begin
                        state <= shift_s;
                        shift_cnt <= '0;
                    end
                shift_s:
                begin
                    shift_cnt <= shift_cnt + 1'b1;
                    if (shift_cnt == bp_pkg::k_last_shift)
                        state <= wait_itr_s;
                end
                default:
                    state <= idle_s;
            endcase
        end
    end

    // --------------------
    // bank addressing
    // --------------------
    always_ff @(posedge clk)
    begin
        if (state == fill_s)
            sh_offset <= sh_offset + lut_val.sh_accu_base;
        else
            sh_offset <= '0;
    end

    // wraps modulo bank depth
    assign fr_s_val = mp_accu_init + sh_offset;

    // returned word lands in its slot
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            cap_en <= 1'b0;
        else
            cap_en <= (state == fill_s);
    end

    always_ff @(posedge clk)
    begin
        cap_idx <= part_idx;
        if (cap_en)
            taps_q[cap_idx] <= fr_val;
    end

    // held steady through shift
    assign taps = taps_q;

    always_comb
    begin
        status.swap = (state == wait_swap_s);
        status.next_itr = (state == idle_s) || (state == wait_itr_s);
        status.pe_en = (state == shift_s);
    end

    // control must only swap a unit that finished filling
    a_swap_ack_legal: assert property (@(posedge clk) disable iff (!reset_n)
        swap_ack |-> status.swap);
    // no refill while shifting
    a_itr_ack_legal: assert property (@(posedge clk) disable iff (!reset_n)
        next_itr_ack |-> (state == idle_s || state == wait_itr_s));

endmodule

// File: bp_swap_control.sv
`timescale 1ns/1ps

module bp_swap_control
(
    input  logic clk,
    input  logic reset_n,
    // angle interface
    input  logic [bp_pkg::k_angle_length-1:0] fr_angle,
    input  logic fr_has_next_angle,
    input  logic fr_next_angle_ack,
    output logic fr_next_angle,
    // bank read ports
    input  bp_pkg::tap_t fr0_val,
    input  bp_pkg::tap_t fr1_val,
    output logic [bp_pkg::k_s_length-1:0] fr0_s_val,
    output logic [bp_pkg::k_s_length-1:0] fr1_s_val,
    // pe side
    output bp_pkg::pe_ctrl_t pe_ctrl,
    output bp_pkg::taps_t pe_taps
);

    typedef enum logic [2:0] {
        ready_s,
        setup_1_s,
        setup_2_s,
        fill_s,
        fill_and_shift_s,
        angle_setup_1_s,
        angle_setup_2_s,
        shift_s
    } state_t;

    state_t state;
    state_t next_state;
    // index of the filling unit, the other one shifts
    logic sw_sel;
    logic [bp_pkg::k_line_itr_length-1:0] line_itr;
    logic [bp_pkg::k_accu_length-1:0] mp_accu_init;
    bp_pkg::lut_val_t lut_val;
    bp_pkg::scan_mode_t scan_mode_q;
    bp_pkg::scan_dir_t scan_dir_q;
    // per-unit links
    bp_pkg::sw_status_t sw0_status;
    bp_pkg::sw_status_t sw1_status;
    bp_pkg::taps_t sw0_taps;
    bp_pkg::taps_t sw1_taps;
    logic sw0_swap_ack;
    logic sw1_swap_ack;
    logic sw0_next_itr_ack;
    logic sw1_next_itr_ack;
    // a is filling, b is shifting
    bp_pkg::sw_status_t swa_status;
    bp_pkg::sw_status_t swb_status;
    logic swa_next_itr_ack;
    logic swb_next_itr_ack;
    logic swap_ack;
    logic last_line;
    logic line_go;
    logic angle_req;
    logic req_q;
    logic angle_taken;

    // --------------------
    // a/b muxes
    // --------------------
    assign swa_status = sw_sel ? sw1_status : sw0_status;
    assign swb_status = sw_sel ? sw0_status : sw1_status;
    assign sw0_next_itr_ack = sw_sel ? swb_next_itr_ack : swa_next_itr_ack;
    assign sw1_next_itr_ack = sw_sel ? swa_next_itr_ack : swb_next_itr_ack;
    assign sw0_swap_ack = !sw_sel && swap_ack;
    assign sw1_swap_ack = sw_sel && swap_ack;

    assign last_line = (line_itr == bp_pkg::k_last_line);
    // a filled, and b done shifting once it has been busy
    assign line_go = (state == fill_s && swa_status.swap) ||
                     (state == fill_and_shift_s && swa_status.swap &&
                      swb_status.next_itr);
    // first fill of a run
    assign swa_next_itr_ack = (state == setup_2_s) && swa_status.next_itr;
    // last line of an angle waits for the new angle's setup bubble
    assign swap_ack = (state == angle_setup_2_s) ||
                      (line_go && (!last_line || !fr_has_next_angle));
    assign swb_next_itr_ack = (state == angle_setup_2_s) || (line_go && !last_line);

    // --------------------
    // angle request
    // --------------------
    // both units stall while the request is out
    assign angle_req = fr_has_next_angle && ((state == ready_s) || (line_go && last_line));
    assign fr_next_angle = req_q && fr_has_next_angle;
    assign angle_taken = fr_next_angle && fr_next_angle_ack;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
            sw_sel <= 1'b0;
            req_q <= 1'b0;
        end
        else
        begin
            state <= next_state;
            req_q <= angle_req && !fr_next_angle_ack;
            if (swap_ack)
                sw_sel <= !sw_sel;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (angle_taken)
                    next_state = setup_1_s;
            setup_1_s:
                next_state = setup_2_s;
            setup_2_s:
                if (swa_status.next_itr)
                    next_state = fill_s;
            fill_s, fill_and_shift_s:
                if (line_go)
                begin
                    if (!last_line)
                        next_state = fill_and_shift_s;
                    else if (!fr_has_next_angle)
                        next_state = shift_s;
                    else if (angle_taken)
                        next_state = angle_setup_1_s;
                end
            angle_setup_1_s:
                next_state = angle_setup_2_s;
            angle_setup_2_s:
                next_state = fill_and_shift_s;
            shift_s:
                // drain the final line
                if (swb_status.next_itr)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // --------------------
    // line iteration
    // --------------------
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            line_itr <= '0;
        else if (state == setup_1_s || state == angle_setup_1_s)
            line_itr <= '0;
        else if (swap_ack && state != angle_setup_2_s)
            line_itr <= line_itr + 1'b1;
    end

    // lut values valid in the second setup cycle
    always_ff @(posedge clk)
    begin
        if (state == setup_2_s || state == angle_setup_2_s)
            mp_accu_init <= lut_val.mp_accu_part;
        else if (swap_ack)
            mp_accu_init <= mp_accu_init - lut_val.mp_accu_base;
    end

    // scan setup per angle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            scan_mode_q <= bp_pkg::scan_x;
            scan_dir_q <= bp_pkg::scan_forward;
        end
        else if (state == setup_2_s || state == angle_setup_2_s)
        begin
            if (fr_angle < bp_pkg::k_angle_45 || fr_angle >= bp_pkg::k_angle_135)
                scan_mode_q <= bp_pkg::scan_x;
            else
                scan_mode_q <= bp_pkg::scan_y;
            if (fr_angle < bp_pkg::k_angle_90)
                scan_dir_q <= bp_pkg::scan_forward;
            else
                scan_dir_q <= bp_pkg::scan_reverse;
        end
    end

    // --------------------
    // units and lut
    // --------------------
    bp_angle_lut u_angle_lut (.clk(clk), .angle(fr_angle), .lut_val(lut_val));

    bp_swappable sw0 (
        .clk(clk), .reset_n(reset_n), .lut_val(lut_val), .mp_accu_init(mp_accu_init),
        .swap_ack(sw0_swap_ack), .next_itr_ack(sw0_next_itr_ack), .fr_val(fr0_val),
        .status(sw0_status), .fr_s_val(fr0_s_val), .taps(sw0_taps)
    );

    bp_swappable sw1 (
        .clk(clk), .reset_n(reset_n), .lut_val(lut_val), .mp_accu_init(mp_accu_init),
        .swap_ack(sw1_swap_ack), .next_itr_ack(sw1_next_itr_ack), .fr_val(fr1_val),
        .status(sw1_status), .fr_s_val(fr1_s_val), .taps(sw1_taps)
    );

    // pe outputs come from the shifting unit
    always_comb
    begin
        pe_ctrl.reset = swa_next_itr_ack;
        pe_ctrl.kick = swap_ack;
        pe_ctrl.en = swb_status.pe_en;
        pe_ctrl.scan_mode = scan_mode_q;
        pe_ctrl.scan_direction = scan_dir_q;
    end
    assign pe_taps = sw_sel ? sw0_taps : sw1_taps;

    // the unit just swapped becomes the shifting side
    a_sel_on_swap: assert property (@(posedge clk) disable iff (!reset_n)
        swap_ack |=> swb_status.pe_en);
    // new run only with both units drained
    a_reset_idle: assert property (@(posedge clk) disable iff (!reset_n)
        pe_ctrl.reset |-> !sw0_status.pe_en && !sw1_status.pe_en);
    // request held until acknowledged
    a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        fr_next_angle && !fr_next_angle_ack |=> fr_next_angle || !fr_has_next_angle);

endmodule

// File: bp_processing_top.sv
`timescale 1ns/1ps

module bp_processing_top
(
    input  logic clk,
    input  logic reset_n,
    // angle interface
    input  logic [bp_pkg::k_angle_length-1:0] fr_angle,
    input  logic fr_has_next_angle,
    input  logic fr_next_angle_ack,
    output logic fr_next_angle,
    // bank load port
    input  logic wr_en,
    input  logic wr_bank,
    input  logic [bp_pkg::k_s_length-1:0] wr_addr,
    input  bp_pkg::tap_t wr_data,
    // pe side
    output bp_pkg::pe_ctrl_t pe_ctrl,
    output bp_pkg::taps_t pe_taps
);

    // bank read links
    logic [bp_pkg::k_s_length-1:0] fr0_s_val;
    logic [bp_pkg::k_s_length-1:0] fr1_s_val;
    bp_pkg::tap_t fr0_val;
    bp_pkg::tap_t fr1_val;

    // --------------------
    // filtered banks
    // --------------------
    bp_filtered_ram u_filtered_ram (
        .clk(clk), .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd0_addr(fr0_s_val), .rd0_data(fr0_val), .rd1_addr(fr1_s_val), .rd1_data(fr1_val)
    );

    // --------------------
    // swap control
    // --------------------
    bp_swap_control u_swap_control (
        .clk(clk), .reset_n(reset_n), .fr_angle(fr_angle),
        .fr_has_next_angle(fr_has_next_angle), .fr_next_angle_ack(fr_next_angle_ack),
        .fr_next_angle(fr_next_angle), .fr0_val(fr0_val), .fr1_val(fr1_val),
        .fr0_s_val(fr0_s_val), .fr1_s_val(fr1_s_val), .pe_ctrl(pe_ctrl), .pe_taps(pe_taps)
    );

endmodule

// File: tb_bp_processing.sv
`timescale 1ns/1ps

module tb_bp_processing;

    // --------------------
    // run sizes
    // --------------------
    localparam int n_angles = 8;
    localparam int total_lines = n_angles * bp_pkg::k_partition_size;
    localparam int load_cycles = bp_pkg::k_no_of_banks * bp_pkg::k_bank_words;
    // rough cost of one line incl. fill, shift and angle bubbles
    localparam int line_budget = 20;
    localparam int margin_cycles = 1848;
    // about 3000 cycles
    localparam int timeout_cycles = load_cycles + total_lines * line_budget + margin_cycles;

    logic clk = 1'b0;
    logic reset_n;
    logic [bp_pkg::k_angle_length-1:0] fr_angle;
    logic fr_has_next_angle;
    logic fr_next_angle_ack;
    logic fr_next_angle;
    logic wr_en;
    logic wr_bank;
    logic [bp_pkg::k_s_length-1:0] wr_addr;
    bp_pkg::tap_t wr_data;
    bp_pkg::pe_ctrl_t pe_ctrl;
    bp_pkg::taps_t pe_taps;

    // reference copy of both banks
    bp_pkg::tap_t bank_model [bp_pkg::k_no_of_banks][bp_pkg::k_bank_words];
    logic [bp_pkg::k_angle_length-1:0] angles [n_angles];
    int acks_served = 0;
    // global line counter L
    int lines_kicked = 0;
    int lines_done = 0;
    int en_run = 0;
    int reset_count = 0;
    int req_rises = 0;
    int cycle_count = 0;
    int cur_angle;
    logic prev_kick = 1'b0;
    logic prev_req = 1'b0;
    bp_pkg::taps_t exp_taps;
    bp_pkg::scan_mode_t exp_mode;
    bp_pkg::scan_dir_t exp_dir;

    bp_processing_top DUT (
        .clk(clk), .reset_n(reset_n), .fr_angle(fr_angle),
        .fr_has_next_angle(fr_has_next_angle), .fr_next_angle_ack(fr_next_angle_ack),
        .fr_next_angle(fr_next_angle), .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
        .wr_data(wr_data), .pe_ctrl(pe_ctrl), .pe_taps(pe_taps)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    // fold, mirror, then look up the slope
    function automatic bp_pkg::lut_val_t lut_from_angle(input int angle);
        bp_pkg::lut_val_t lv;
        int folded;
        int mirrored;
        int slope;
        folded = (angle < 90) ? angle : angle - 90;
        mirrored = (folded < 45) ? folded : 89 - folded;
        slope = int'(bp_pkg::k_slope_table[mirrored / 4]);
        lv.sh_accu_base = 8'(slope + 16);
        lv.mp_accu_base = 8'(slope / 4 + 1);
        lv.mp_accu_part = 8'((angle + 64) % 256);
        return lv;
    endfunction

    // tap p of global line L
    function automatic bp_pkg::tap_t expected_tap(input int line, input int p);
        bp_pkg::lut_val_t lv;
        int step;
        int addr;
        lv = lut_from_angle(int'(angles[line / bp_pkg::k_partition_size]));
        step = line % bp_pkg::k_partition_size;
        addr = int'(lv.mp_accu_part) - step * int'(lv.mp_accu_base) +
               p * int'(lv.sh_accu_base);
        // wrap to bank depth, negative sums too
        addr = ((addr % bp_pkg::k_bank_words) + bp_pkg::k_bank_words) % bp_pkg::k_bank_words;
        return bank_model[line % 2][addr];
    endfunction

    // --------------------
    // stimulus
    // --------------------
    task automatic load_banks();
        logic [31:0] word;
        for (int b = 0; b < bp_pkg::k_no_of_banks; b++)
        begin
            for (int a = 0; a < bp_pkg::k_bank_words; a++)
            begin
                word = $urandom;
                bank_model[b][a] = word[bp_pkg::k_filtered_data_length-1:0];
                @(posedge clk);
                wr_en <= 1'b1;
                wr_bank <= b[0];
                wr_addr <= a[bp_pkg::k_s_length-1:0];
                wr_data <= word[bp_pkg::k_filtered_data_length-1:0];
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // angle source, ack 0 to 3 cycles after the request
    task automatic serve_angles();
        int wait_cycles;
        fr_has_next_angle <= 1'b1;
        for (int k = 0; k < n_angles; k++)
        begin
            do
                @(negedge clk);
            while (!fr_next_angle);
            wait_cycles = $urandom_range(3, 0);
            repeat (wait_cycles) @(posedge clk);
            @(posedge clk);
            // new angle comes with the ack
            fr_next_angle_ack <= 1'b1;
            fr_angle <= angles[k];
            acks_served++;
            @(posedge clk);
            fr_next_angle_ack <= 1'b0;
            // last angle served, nothing more to offer
            if (k == n_angles - 1)
                fr_has_next_angle <= 1'b0;
        end
    endtask

    // --------------------
    // output monitor
    // --------------------
    // sampled mid-cycle, away from the drive edge
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (pe_ctrl.reset)
                reset_count++;
            if (pe_ctrl.en)
            begin
                // run opens right behind its kick
                if (en_run == 0)
                    check_value(prev_kick, 1, "pe_en start one cycle after pe_kick");
                en_run++;
                check_value(en_run <= bp_pkg::k_shift_cycles, 1, "pe_en run too long");
                for (int p = 0; p < bp_pkg::k_no_of_partitions; p++)
                    check_value(pe_taps[p], exp_taps[p],
                                $sformatf("line %0d tap %0d", lines_kicked - 1, p));
            end
            else if (en_run != 0)
            begin
                check_value(en_run, bp_pkg::k_shift_cycles, "pe_en run length");
                en_run = 0;
                lines_done++;
            end
            // kick may come in the cycle the previous run closes
            if (pe_ctrl.kick)
            begin
                check_value(reset_count, 1, "pe_reset count at pe_kick");
                check_value(pe_ctrl.en, 0, "pe_en high in kick cycle");
                check_value(lines_kicked < acks_served * bp_pkg::k_partition_size, 1,
                            "pe_kick beyond served angles");
                cur_angle = int'(angles[lines_kicked / bp_pkg::k_partition_size]);
                exp_mode = (cur_angle < 45 || cur_angle >= 135) ? bp_pkg::scan_x : bp_pkg::scan_y;
                exp_dir = (cur_angle < 90) ? bp_pkg::scan_forward : bp_pkg::scan_reverse;
                check_value(pe_ctrl.scan_mode, exp_mode, "scan_mode at pe_kick");
                check_value(pe_ctrl.scan_direction, exp_dir, "scan_direction at pe_kick");
                for (int p = 0; p < bp_pkg::k_no_of_partitions; p++)
                    exp_taps[p] = expected_tap(lines_kicked, p);
                lines_kicked++;
            end
            // request only while angles remain
            check_value(!fr_next_angle || fr_has_next_angle, 1,
                        "fr_next_angle without fr_has_next_angle");
            if (fr_next_angle && !prev_req)
                req_rises++;
            prev_kick = pe_ctrl.kick;
            prev_req = fr_next_angle;
        end
    end

    // hang guard
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_count);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        void'($urandom(36531));
        reset_n = 1'b0;
        fr_angle = '0;
        fr_has_next_angle = 1'b0;
        fr_next_angle_ack = 1'b0;
        wr_en = 1'b0;
        wr_bank = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        for (int k = 0; k < n_angles; k++)
            angles[k] = 8'($urandom_range(179, 0));
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        // first cycle out of reset is quiet
        @(negedge clk);
        check_value(fr_next_angle, 0, "fr_next_angle after reset");
        check_value(pe_ctrl.reset, 0, "pe_reset after reset");
        check_value(pe_ctrl.kick, 0, "pe_kick after reset");
        check_value(pe_ctrl.en, 0, "pe_en after reset");
        load_banks();
        serve_angles();
        while (lines_done < total_lines)
            @(negedge clk);
        // let the last line drain back to idle
        repeat (4) @(negedge clk);
        check_value(fr_next_angle, 0, "fr_next_angle at idle");
        check_value(pe_ctrl.en, 0, "pe_en at idle");
        check_value(pe_ctrl.kick, 0, "pe_kick at idle");
        check_value(lines_kicked, total_lines, "total pe_kick count");
        check_value(req_rises, n_angles, "fr_next_angle requests");
        check_value(reset_count, 1, "pe_reset pulses");
        $display("test passed");
        $finish;
    end

endmodule

// File: bp_processing_top.f
bp_pkg.sv
bp_filtered_ram.sv
bp_angle_lut.sv
bp_swappable.sv
bp_swap_control.sv
bp_processing_top.sv
tb_bp_processing.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the log
verilator --binary --timing -Wno-fatal --top-module tb_bp_processing \
    -f bp_processing_top.f -o sim_bp > build.log 2>&1 || { echo "build error"; exit 1; }
./obj_dir/sim_bp > sim.log 2>&1
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
